/* test/pcs_tx_stim.txt */
// columns: repeat count, ctrl flag, expected sync header, 64-bit payload, all hex
// control payloads carry the block type in the low byte, 200 blocks in total
// idle run from reset
08 1 2 000000000000001E
// start with preamble, then a long zero run
01 1 2 5555555555555578
10 0 1 0000000000000000
01 0 1 0123456789ABCDEF
01 0 1 FEDCBA9876543210
28 0 1 0000000000000000
01 0 1 FFFFFFFFFFFFFFFF
// terminate, idle gap
01 1 2 00000000000000FF
0C 1 2 000000000000001E
01 1 2 D555555555555578
20 0 1 A5A5A5A5A5A5A5A5
01 0 1 8000000000000001
01 1 2 0000000000000087
18 0 1 0000000000000000
// ordered sets
04 1 2 000000000000004B
01 0 1 DEADBEEFCAFEF00D
30 0 1 0000000000000000
01 1 2 00000000000000FF
06 1 2 000000000000001E

/* all.f */
hw/pcs_tx_pkg.sv
hw/pcs_tx_ctrl.sv
hw/pcs_tx_scrambler.sv
hw/pcs_tx_gearbox.sv
hw/pcs_tx_top.sv
test/pcs_tx_properties.sv
test/pcs_tx_tb.sv

/* Makefile */
LOG := sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module pcs_tx_tb -f all.f
	./obj_dir/Vpcs_tx_tb > $(LOG) 2>&1 || echo ">>> FAIL" >> $(LOG)
	cat $(LOG)
	! grep -q ">>> FAIL" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* test/pcs_tx_tb.sv */
/*
 * testbench for the transmit PCS
 *  - clock, reset and block stimulus from the data file
 *  - serial scrambler and bit stream reference built from the packing rules
 *  - compare tasks for words, ready, valid and sync headers
 *  - watchdog and closing verdict
 */
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_tb import pcs_tx_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int BLOCK_N      = 200;
	localparam int REC_N        = 19;
	localparam int SKIP_N       = SEQ_FULL + 1;
	// words needed to carry every stimulus bit
	localparam int WORDS_N      = (BLOCK_N * (HEAD_W + BLOCK_W) + WORD_W - 1) / WORD_W;
	localparam int WATCHDOG_NS  = BLOCK_N * CLK_PERIOD * 2;

	logic              clk;
	logic              rst_n;
	mac_block_s        block;
	logic              ready;
	logic [WORD_W-1:0] word;
	logic              word_valid;

	// four tokens per record
	logic [63:0]       stim_mem [0:REC_N*4-1];
	mac_block_s        blocks_q [$];
	logic [HEAD_W-1:0] heads_q [$];

	// reference wire stream, earliest bit at the front
	bit                stream_q [$];
	longint unsigned   head_off_q [$];
	logic [HEAD_W-1:0] head_exp_q [$];
	// index 0 is s(n-58), top index is s(n-1)
	logic [SCR_W-1:0]  ref_state;
	longint unsigned   pushed_bits;
	longint unsigned   popped_bits;

	int err_word;
	int err_ready;
	int err_head;
	int err_valid;
	int err_other;

	pcs_tx_top dut0 (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.block_i      (block),
		.ready_o      (ready),
		.word_o       (word),
		.word_valid_o (word_valid)
	);

	initial begin
		clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp);
		if (got !== exp) begin
			err_word++;
			$display("Fail %0t word_o got %h exp %h", $time, got, exp);
		end
	endtask

	task automatic check_ready(input logic got, input logic exp);
		if (got !== exp) begin
			err_ready++;
			$display("Fail %0t ready_o got %b exp %b", $time, got, exp);
		end
	endtask

	task automatic verify_valid(input logic got, input logic exp);
		if (got !== exp) begin
			err_valid++;
			$display("Fail %0t word_valid_o got %b exp %b", $time, got, exp);
		end
	endtask

	task automatic verify_head(input logic [HEAD_W-1:0] got, input logic [HEAD_W-1:0] exp,
			input longint unsigned pos);
		if (got !== exp) begin
			err_head++;
			$display("Fail %0t word_o header at stream bit %0d got %b exp %b",
				$time, pos, got, exp);
		end
	endtask

	// expand run length records into single blocks
	task automatic load_stim();
		logic [63:0]       cnt;
		mac_block_s        blk;
		logic [HEAD_W-1:0] head;
		$readmemh("test/pcs_tx_stim.txt", stim_mem);
		for (int r = 0; r < REC_N; r++) begin
			cnt         = stim_mem[4*r];
			blk.ctrl    = stim_mem[4*r+1][0];
			head        = stim_mem[4*r+2][HEAD_W-1:0];
			blk.payload = stim_mem[4*r+3];
			// control blocks always name a block type
			if (blk.ctrl && blk.payload.ctrl.block_type == 8'h00) begin
				err_other++;
				$display("stimulus record %0d is a control block without a block type", r);
			end
			if (head !== (blk.ctrl ? 2'b10 : 2'b01)) begin
				err_other++;
				$display("stimulus record %0d has a header that disagrees with its flag", r);
			end
			for (int n = 0; n < int'(cnt); n++) begin
				blocks_q.push_back(blk);
				heads_q.push_back(head);
			end
		end
		if (blocks_q.size() != BLOCK_N) begin
			err_other++;
			$display("stimulus file gave %0d blocks instead of %0d",
				blocks_q.size(), BLOCK_N);
		end
	endtask

	// header bits first, then payload scrambled bit by bit, LSB first
	task automatic push_coded(input mac_block_s blk, input logic [HEAD_W-1:0] head);
		logic [BLOCK_W-1:0] data;
		logic               s;
		data = blk.payload;
		head_off_q.push_back(pushed_bits);
		head_exp_q.push_back(head);
		stream_q.push_back(head[0]);
		stream_q.push_back(head[1]);
		for (int b = 0; b < BLOCK_W; b++) begin
			// s(n) = d(n) ^ s(n-39) ^ s(n-58)
			s = data[b] ^ ref_state[SCR_W-SCR_TAP] ^ ref_state[0];
			ref_state = {s, ref_state[SCR_W-1:1]};
			stream_q.push_back(s);
		end
		pushed_bits += HEAD_W + BLOCK_W;
	endtask

	task automatic pop_word(output logic [WORD_W-1:0] w);
		w = '0;
		for (int b = 0; b < WORD_W; b++) begin
			w[b] = stream_q.pop_front();
		end
		popped_bits += WORD_W;
	endtask

	// headers never straddle a word, 66n mod 64 is even
	task automatic scan_heads(input logic [WORD_W-1:0] got, input longint unsigned base);
		longint unsigned pos;
		int              off;
		while (head_off_q.size() > 0 && head_off_q[0] < base + WORD_W) begin
			pos = head_off_q.pop_front();
			off = int'(pos - base);
			verify_head(got[off +: HEAD_W], head_exp_q.pop_front(), pos);
		end
	endtask

	initial begin
		int                cyc;
		int                blk_idx;
		int                words_done;
		int                err_total;
		longint unsigned   base;
		logic [WORD_W-1:0] exp_word;
		logic [HEAD_W-1:0] head;
		void'($urandom(32'h55e0abd1));
		rst_n       = 1'b0;
		block       = '0;
		ref_state   = '1;
		pushed_bits = 0;
		popped_bits = 0;
		err_word    = 0;
		err_ready   = 0;
		err_head    = 0;
		err_valid   = 0;
		err_other   = 0;
		load_stim();

		// ready and valid stay low while reset is held
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#2;
			check_ready(ready, 1'b0);
			verify_valid(word_valid, 1'b0);
		end
		rst_n      = 1'b1;
		cyc        = 0;
		blk_idx    = 0;
		words_done = 0;

		while (words_done < WORDS_N) begin
			@(posedge clk);
			#2;
			// skip slot predicted from the cycle count
			check_ready(ready, (cyc % SKIP_N) != SEQ_FULL);
			verify_valid(word_valid, cyc >= 1);
			if (cyc >= 1) begin
				if (stream_q.size() < WORD_W) begin
					err_other++;
					$display("reference stream ran out of bits at cycle %0d", cyc);
				end else begin
					base = popped_bits;
					pop_word(exp_word);
					check_word(word, exp_word);
					scan_heads(word, base);
				end
				words_done++;
			end
			// next block, poison on the skip slot
			if (ready) begin
				if (blk_idx < BLOCK_N) begin
					block = blocks_q[blk_idx];
					head  = heads_q[blk_idx];
					blk_idx++;
				end else begin
					// idle control blocks once the file is used up
					block.ctrl    = 1'b1;
					block.payload = 64'h0000_0000_0000_001E;
					head          = 2'b10;
				end
				push_coded(block, head);
			end else begin
				block.ctrl    = 1'b1;
				block.payload = 64'hBADC_0FFE_E0DD_F00D;
			end
			cyc++;
		end

		err_total = err_word + err_ready + err_head + err_valid + err_other;
		$display("errors: word %0d, ready %0d, header %0d, valid %0d, other %0d, total %0d",
			err_word, err_ready, err_head, err_valid, err_other, err_total);
		if (err_total == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// twice the time the block count needs
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, output stream did not finish", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* test/pcs_tx_properties.sv */
/*
 * concurrent checks on the transmit pacing, bound to the controller
 *  - sequence count bounded by the full slot
 *  - skip slot lasts one cycle and wraps the count
 *  - skip slot follows the last data slot
 *  - ready held low through reset
 */
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_properties import pcs_tx_pkg::*; (
	input wire             clk,
	input wire             rst_n_i,
	input wire             ready_i,
	input wire [SEQ_W-1:0] seq_i
);

	// count only runs 0..32
	seq_bound: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		seq_i <= SEQ_W'(SEQ_FULL)
	) else $error("sequence count %0d above the full slot", seq_i);

	// one skip cycle, then slot 0 with ready back up
	ready_wrap: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!ready_i |=> (ready_i && seq_i == '0)
	) else $error("ready low for more than one cycle or count %0d did not wrap", seq_i);

	// last data slot hands over to the skip slot
	ready_skip: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(ready_i && seq_i == SEQ_W'(SEQ_FULL - 1)) |=> !ready_i
	) else $error("ready stayed high after slot %0d", SEQ_FULL - 1);

	// reset parks the count on the full slot
	// so ready is low one edge later
	ready_in_reset: assert property (
		@(posedge clk)
		!rst_n_i |=> !ready_i
	) else $error("ready high while reset was applied");

endmodule

// attach to every controller instance
bind pcs_tx_ctrl pcs_tx_properties props0 (
	.clk     (clk),
	.rst_n_i (rst_n_i),
	.ready_i (ready_o),
	.seq_i   (seq_q)
);

`default_nettype wire

/* hw/pcs_tx_top.sv */
/*
 * transmit PCS top
 *  - pacing controller
 *  - header select and scrambler
 *  - 66 to 64 gearbox
 */
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_top import pcs_tx_pkg::*; (
	input  wire               clk,
	input  wire               rst_n_i,
	input  mac_block_s        block_i,
	output logic              ready_o,
	output logic [WORD_W-1:0] word_o,
	output logic              word_valid_o
);

	logic             ready;
	logic [SEQ_W-1:0] seq;
	coded_block_s     coded;

	// counter, ready and the delayed slot
	pcs_tx_ctrl ctrl0 (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.ready_o      (ready),
		.word_valid_o (word_valid_o),
		.seq_o        (seq)
	);

	// a block is taken on every ready cycle, no gaps
	pcs_tx_scrambler scr0 (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.accept_i (ready),
		.block_i  (block_i),
		.block_o  (coded)
	);

	// slot lines up with the registered coded block
	pcs_tx_gearbox gb0 (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.seq_i   (seq),
		.block_i (coded),
		.word_o  (word_o)
	);

	assign ready_o = ready;

endmodule

`default_nettype wire

/* hw/pcs_tx_gearbox.sv */
/*
 * 66 to 64 bit transmit gearbox
 *  - one hot slot select from the sequence count
 *  - residue register holding leftover payload bits
 *  - output merge of residue, header and low payload
 *  - slot 32 drains the residue as a full word
 */
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_gearbox import pcs_tx_pkg::*; (
	input  wire               clk,
	input  wire               rst_n_i,
	input  wire [SEQ_W-1:0]   seq_i,
	input  coded_block_s      block_i,
	output logic [WORD_W-1:0] word_o
);

	// one step per header width
	localparam int unsigned SHIFT_N = WORD_W / HEAD_W;
	localparam int unsigned CODED_W = HEAD_W + BLOCK_W;

	// block in wire order, header in the low bits
	logic [CODED_W-1:0] coded;

	logic [SHIFT_N:0]   shift_sel;

	// per slot candidates
	logic [WORD_W-1:0]  low_arr  [SHIFT_N];
	logic [WORD_W-1:0]  high_arr [SHIFT_N];
	logic [SHIFT_N-1:0] rd_lite_arr [SHIFT_N];
	logic [SHIFT_N-1:0] wr_lite_arr [SHIFT_N];

	// selected slot
	logic [WORD_W-1:0]  low_sel;
	logic [WORD_W-1:0]  high_sel;
	logic [SHIFT_N-1:0] rd_lite;
	logic [SHIFT_N-1:0] wr_lite;

	// masks expanded to bit level
	logic [WORD_W-1:0]  rd_mask;
	logic [WORD_W-1:0]  wr_mask;

	logic [WORD_W-1:0]  residue_q;
	logic [WORD_W-1:0]  residue_d;

	assign coded = {block_i.payload, block_i.head};

	genvar i;
	generate
		for (i = 0; i < SHIFT_N; i++) begin : slot_loop
			// slot i holds 2i residue bits
			// header lands right above them
			assign low_arr[i]  = WORD_W'(coded << (HEAD_W * i));
			// top 2i+2 payload bits do not fit, keep them
			assign high_arr[i] = WORD_W'(coded >> (WORD_W - HEAD_W * i));
			// residue lanes read this slot
			assign rd_lite_arr[i] = ~({SHIFT_N{1'b1}} << i);
			// residue lanes written for the next slot
			assign wr_lite_arr[i] = ~({SHIFT_N{1'b1}} << (i + 1));
		end
		for (i = 0; i <= SHIFT_N; i++) begin : sel_loop
			assign shift_sel[i] = (seq_i == SEQ_W'(i));
		end
	endgenerate

	// one hot mux over the slots
	always_comb begin
		low_sel  = '0;
		high_sel = '0;
		rd_lite  = '0;
		wr_lite  = '0;
		for (int x = 0; x < SHIFT_N; x++) begin
			if (shift_sel[x]) begin
				low_sel  |= low_arr[x];
				high_sel |= high_arr[x];
				rd_lite  |= rd_lite_arr[x];
				wr_lite  |= wr_lite_arr[x];
			end
		end
		// full slot, whole word from residue, nothing left over
		if (shift_sel[SHIFT_N]) begin
			rd_lite = '1;
		end
	end

	// each lite bit covers one header width of bits
	generate
		for (i = 0; i < SHIFT_N; i++) begin : mask_loop
			assign rd_mask[i*HEAD_W +: HEAD_W] = {HEAD_W{rd_lite[i]}};
			assign wr_mask[i*HEAD_W +: HEAD_W] = {HEAD_W{wr_lite[i]}};
		end
	endgenerate

	// leftover payload masked into the residue
	assign residue_d = wr_mask & high_sel;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			residue_q <= '0;
		end else begin
			residue_q <= residue_d;
		end
	end

	// oldest bits first, residue below the new block
	assign word_o = (rd_mask & residue_q) | (~rd_mask & low_sel);

endmodule

`default_nettype wire

/* hw/pcs_tx_scrambler.sv */
/*
 * sync header select and payload scrambler
 *  - header from the MAC control flag
 *  - self synchronous x^58 + x^39 + 1 scrambler, 64 bits per cycle
 *  - registered coded block, held on skip cycles
 */
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_scrambler import pcs_tx_pkg::*; (
	input  wire          clk,
	input  wire          rst_n_i,
	input  wire          accept_i,
	input  mac_block_s   block_i,
	output coded_block_s block_o
);

	// scrambler history, bit 0 is the latest scrambled bit
	logic [SCR_W-1:0]   scr_q;
	logic [SCR_W-1:0]   scr_d;

	logic [BLOCK_W-1:0] raw_payload;
	logic [BLOCK_W-1:0] scr_payload;
	logic [HEAD_W-1:0]  head;

	coded_block_s       block_q;

	// payload taken as a plain word, both views share the bits
	assign raw_payload = block_i.payload;

	// control blocks get 10, data blocks 01
	assign head = block_i.ctrl ? SYNC_CTRL : SYNC_DATA;

	// serial scrambler unrolled over the word
	// LSB goes first on the wire so it is scrambled first
	always_comb begin
		scr_d = scr_q;
		for (int b = 0; b < BLOCK_W; b++) begin
			// s(n) = d(n) ^ s(n-39) ^ s(n-58)
			scr_payload[b] = raw_payload[b] ^ scr_d[SCR_TAP-1] ^ scr_d[SCR_W-1];
			scr_d = {scr_d[SCR_W-2:0], scr_payload[b]};
		end
	end

	// state only moves on accepted blocks
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			scr_q <= '1;
		end else if (accept_i) begin
			scr_q <= scr_d;
		end
	end

	// coded block stage
	// held through the skip slot, the gearbox drains residue then
	always_ff @(posedge clk) begin
		if (accept_i) begin
			block_q.head    <= head;
			block_q.payload <= scr_payload;
		end
	end

	assign block_o = block_q;

endmodule

`default_nettype wire

/* hw/pcs_tx_ctrl.sv */
/*
 * transmit pacing
 *  - free running 0..32 sequence counter
 *  - ready toward the MAC, low on the skip slot
 *  - one cycle delayed sequence for the gearbox
 *  - output word valid flag
 */
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_ctrl import pcs_tx_pkg::*; (
	input  wire              clk,
	input  wire              rst_n_i,
	output logic             ready_o,
	output logic             word_valid_o,
	output logic [SEQ_W-1:0] seq_o
);

	logic [SEQ_W-1:0] seq_q;
	logic [SEQ_W-1:0] seq_next;
	logic [SEQ_W-1:0] seq_d_q;
	logic             word_valid_q;

	// wrap from full back to zero
	assign seq_next = (seq_q == SEQ_W'(SEQ_FULL)) ? '0 : seq_q + 1'b1;

	// reset parks the count on the skip slot
	// so ready stays low, first count after reset is 0
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			seq_q <= SEQ_W'(SEQ_FULL);
		end else begin
			seq_q <= seq_next;
		end
	end

	// gearbox sees the slot of the block now leaving the scrambler
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			seq_d_q <= SEQ_W'(SEQ_FULL);
		end else begin
			seq_d_q <= seq_q;
		end
	end

	// set once the first block is taken, stays up
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			word_valid_q <= 1'b0;
		end else begin
			word_valid_q <= word_valid_q | ready_o;
		end
	end

	// buffer full on slot 32, MAC skips this cycle
	assign ready_o      = (seq_q != SEQ_W'(SEQ_FULL));
	assign seq_o        = seq_d_q;
	assign word_valid_o = word_valid_q;

endmodule

`default_nettype wire

/* hw/pcs_tx_pkg.sv */
/*
 * transmit PCS shared definitions
 *  - block, header and gearbox word widths
 *  - sequence count limits for the gearbox pacing
 *  - sync header codes and scrambler taps
 *  - MAC block and coded block types
 */
`default_nettype none

package pcs_tx_pkg;

	// block geometry
	localparam int unsigned BLOCK_W = 64;
	localparam int unsigned HEAD_W  = 2;
	localparam int unsigned WORD_W  = 64;

	// gearbox pacing, 2 extra bits per block so 32 blocks fill one word
	localparam int unsigned SEQ_FULL = 32;
	localparam int unsigned SEQ_W    = 6;

	// sync headers, never scrambled
	localparam logic [HEAD_W-1:0] SYNC_DATA = 2'b01;
	localparam logic [HEAD_W-1:0] SYNC_CTRL = 2'b10;

	// x^58 + x^39 + 1
	localparam int unsigned SCR_W   = 58;
	localparam int unsigned SCR_TAP = 39;

	// control view of a block payload
	// block type sits in the low byte, first on the wire
	typedef struct packed {
		logic [BLOCK_W-9:0] ctrl_data;
		logic [7:0]         block_type;
	} ctrl_view_s;

	// one payload word, read either as bytes or as a control block
	// byte 0 in the low bits
	typedef union packed {
		logic [7:0][7:0] bytes;
		ctrl_view_s      ctrl;
	} block_payload_u;

	// block as delivered by the MAC
	typedef struct packed {
		logic           ctrl;
		block_payload_u payload;
	} mac_block_s;

	// 66 bit coded block, header plus scrambled payload
	typedef struct packed {
		logic [HEAD_W-1:0]  head;
		logic [BLOCK_W-1:0] payload;
	} coded_block_s;

endpackage

`default_nettype wire
